// File: all.f
source/bp_dma_pkg.sv
source/dma_burst_engine.sv
source/mem_bus_arbiter.sv
source/bp_dma_mem_top.sv
bench/bp_dma_mem_assert.sv
bench/tb_bp_dma_mem.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_bp_dma_mem
FILELIST = all.f
OBJDIR   = obj_dir
LOG      = sim.log
FAIL_MSG = Finished with errors
PASS_MSG = Finished with no errors

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "TEST FAILED"; exit 1; else echo "TEST PASSED"; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/tb_bp_dma_mem.sv
/* Testbench for the two-bank DMA memory path with LFSR stimulus, bank and RAM
   models, reference memory, checks and watchdog */

module tb_bp_dma_mem;

   import bp_dma_pkg::*;

   localparam int clk_period_c   = 10;
   localparam int burst_cycles_c = 64;
   localparam int rand_pkts_c    = 10;
   localparam int rr_pkts_c      = 6;
   localparam int total_bursts_c = 2 + 4 + 2 * rand_pkts_c + 2 * rr_pkts_c;

   logic          clk_i;
   logic          rst_n_i;
   logic   [1:0]  pkt_v_i = '0;
   logic   [1:0]  pkt_write_not_read_i = '0;
   daddr_t [1:0]  pkt_addr_i = '0;
   logic   [1:0]  pkt_yumi_o;
   logic   [1:0]  wdata_v_i = '0;
   fill_t  [1:0]  wdata_i = '0;
   logic   [1:0]  wdata_yumi_o;
   logic   [1:0]  rdata_v_o;
   fill_t  [1:0]  rdata_o;
   logic   [1:0]  rdata_ready_i = '0;
   logic          mem_v_o;
   logic          mem_w_o;
   paddr_t        mem_addr_o;
   fill_t         mem_wdata_o;
   fill_t         mem_rdata_i = '0;

   // Bank models and expected traffic per bank
   logic [daddr_width_c:0]              pkt_q [2][$];
   fill_t                               wr_q  [2][$];
   fill_t                               rd_q  [2][$];
   logic [paddr_width_c+fill_width_c:0] bus_q [2][$];
   fill_t                               ram [paddr_t];
   fill_t                               ref_mem [paddr_t];
   fill_t                               rd_word = '0;

   logic [31:0] lfsr = 32'd95850;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          i;
   logic        rr_on = 1'b0;
   logic        rr_last = 1'b0;
   logic [1:0]  strobe_cnt = '0;

   bp_dma_mem_top dut (.*);

   // Taps 32, 22, 2, 1
   function automatic logic rand_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          k;
      v = '0;
      for (k = 0; k < n; k++)
         v = {v[30:0], rand_bit()};
      return v;
   endfunction

   // Contents of a word never written
   function automatic fill_t fill_word(input paddr_t a);
      return {2'b10, a, a};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic add_packet(input int b, input logic w, input daddr_t addr);
      int     n;
      paddr_t pa;
      fill_t  d;
      pkt_q[b].push_back({w, addr});
      for (n = 0; n < burst_len_c; n++)
      begin
         // Block bits, then bank, then beat
         pa = {addr[daddr_width_c-1:2], b[0], n[1:0]};
         if (w)
         begin
            d = rand_bits(fill_width_c);
            wr_q[b].push_back(d);
            ref_mem[pa] = d;
         end
         else
         begin
            d = ref_mem.exists(pa) ? ref_mem[pa] : fill_word(pa);
            rd_q[b].push_back(d);
         end
         bus_q[b].push_back({w, pa, d});
      end
   endtask

   task automatic add_random(input int b);
      logic w;
      w = rand_bit();
      add_packet(b, w, daddr_t'(rand_bits(5)));
   endtask

   task automatic wait_drained();
      int   b;
      logic busy;
      busy = 1'b1;
      while (busy)
      begin
         @(negedge clk_i);
         busy = 1'b0;
         for (b = 0; b < 2; b++)
            if (pkt_q[b].size() + wr_q[b].size() + rd_q[b].size() + bus_q[b].size() != 0)
               busy = 1'b1;
      end
      repeat (2) @(negedge clk_i);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s finished, errors so far %0d", tests, name, errors);
   endtask

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #(clk_period_c / 2);
         clk_i = ~clk_i;
      end
   end

   // Sample at the edge and then drive the bank and RAM models
   always @(posedge clk_i)
   begin
      int                                  b;
      int                                  bk;
      logic [paddr_width_c+fill_width_c:0] e;
      if (rst_n_i)
      begin
         for (b = 0; b < 2; b++)
         begin
            if (pkt_yumi_o[b] && pkt_q[b].size() != 0)
               void'(pkt_q[b].pop_front());
            if (wdata_yumi_o[b] && wr_q[b].size() != 0)
               void'(wr_q[b].pop_front());
            if (rdata_v_o[b] && rdata_ready_i[b])
            begin
               if (rd_q[b].size() == 0)
               begin
                  errors++;
                  $display("bank %0d took a read word with no read pending", b);
               end
               else
                  check_value("rdata_o", rdata_o[b], rd_q[b].pop_front());
            end
         end
         if (mem_v_o)
         begin
            bk = mem_addr_o[beat_width_c];
            if (bus_q[bk].size() == 0)
            begin
               errors++;
               $display("memory strobe at %h with no access pending", mem_addr_o);
            end
            else
            begin
               e = bus_q[bk].pop_front();
               check_value("mem_w_o", mem_w_o, e[paddr_width_c+fill_width_c]);
               check_value("mem_addr_o", mem_addr_o, e[fill_width_c +: paddr_width_c]);
               if (mem_w_o)
                  check_value("mem_wdata_o", mem_wdata_o, e[fill_width_c-1:0]);
            end
            if (mem_w_o)
               ram[mem_addr_o] = mem_wdata_o;
            else
               rd_word = ram.exists(mem_addr_o) ? ram[mem_addr_o] : fill_word(mem_addr_o);
            // First strobe of a burst carries its bank
            if (strobe_cnt == 2'd0)
            begin
               if (rr_on)
                  check_value("burst bank", bk, !rr_last);
               rr_last = bk[0];
            end
            strobe_cnt = strobe_cnt + 2'd1;
         end
      end
      #1;
      for (b = 0; b < 2; b++)
      begin
         pkt_v_i[b] = (pkt_q[b].size() != 0);
         if (pkt_v_i[b])
            {pkt_write_not_read_i[b], pkt_addr_i[b]} = pkt_q[b][0];
         wdata_v_i[b]     = (wr_q[b].size() != 0) && rand_bit();
         wdata_i[b]       = (wr_q[b].size() != 0) ? wr_q[b][0] : fill_t'(0);
         rdata_ready_i[b] = rand_bit();
      end
      mem_rdata_i = rd_word;
   end

   initial
   begin
      #((total_bursts_c * burst_cycles_c + 100) * clk_period_c);
      $display("timeout: the bursts did not finish in the time allowed");
      $display("Finished with errors");
      $finish;
   end

   initial
   begin
      rst_n_i = 1'b0;
      repeat (3) @(posedge clk_i);
      #1 rst_n_i = 1'b1;

      repeat (2) @(negedge clk_i);
      check_value("pkt_yumi_o", pkt_yumi_o, 0);
      check_value("wdata_yumi_o", wdata_yumi_o, 0);
      check_value("rdata_v_o", rdata_v_o, 0);
      check_value("mem_v_o", mem_v_o, 0);
      check_value("bus_gnt", dut.bus_gnt, 0);
      end_test("reset");

      // Nonzero low address bits that the decode ignores
      add_packet(1, 1'b1, 14'h1a7);
      wait_drained();
      end_test("write decode");

      add_packet(1, 1'b0, 14'h1a4);
      wait_drained();
      end_test("read back");

      // Same bank-local block on both banks
      add_packet(0, 1'b1, 14'h0040);
      add_packet(1, 1'b1, 14'h0040);
      add_packet(0, 1'b0, 14'h0040);
      add_packet(1, 1'b0, 14'h0040);
      for (i = 0; i < rand_pkts_c; i++)
      begin
         add_random(0);
         add_random(1);
      end
      wait_drained();
      end_test("concurrent banks");

      // Both engines request together at the start of this test
      rr_on = 1'b1;
      for (i = 0; i < rr_pkts_c; i++)
      begin
         add_random(0);
         add_random(1);
      end
      wait_drained();
      rr_on = 1'b0;
      end_test("round robin");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// File: bench/bp_dma_mem_assert.sv
/* Concurrent checks on the bus grant and the bank handshakes, bound to the top */

module bp_dma_mem_assert
  (input                                                    clk_i
   , input                                                  rst_n_i
   , input        [bp_dma_pkg::l2_banks_c-1:0]              gnt_i
   , input        [bp_dma_pkg::l2_banks_c-1:0]              pkt_v_i
   , input        [bp_dma_pkg::l2_banks_c-1:0]              pkt_yumi_i
   , input        [bp_dma_pkg::l2_banks_c-1:0]              rdata_v_i
   , input  bp_dma_pkg::fill_t [bp_dma_pkg::l2_banks_c-1:0] rdata_i
   , input        [bp_dma_pkg::l2_banks_c-1:0]              rdata_ready_i
   );

   import bp_dma_pkg::*;

   grant_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(gnt_i[0] && gnt_i[1]))
      else $error("both engines hold the memory bus grant");

   for (genvar b = 0; b < l2_banks_c; b++)
   begin : bank
      yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         pkt_yumi_i[b] |-> pkt_v_i[b])
         else $error("packet consumed on bank %0d without a valid packet", b);

      // Read word held until the bank takes it
      rdata_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         rdata_v_i[b] && !rdata_ready_i[b] |=> rdata_v_i[b] && $stable(rdata_i[b]))
         else $error("read data on bank %0d dropped or changed before ready", b);
   end

endmodule

bind bp_dma_mem_top bp_dma_mem_assert assertions
  (.clk_i(clk_i), .rst_n_i(rst_n_i), .gnt_i(bus_gnt), .pkt_v_i(pkt_v_i)
   , .pkt_yumi_i(pkt_yumi_o), .rdata_v_i(rdata_v_o), .rdata_i(rdata_o)
   , .rdata_ready_i(rdata_ready_i));

// File: source/bp_dma_mem_top.sv
/* Two cache bank DMA burst engines sharing one RAM-style memory port */

module bp_dma_mem_top
  (input                                                      clk_i
   , input                                                    rst_n_i

   // Cache bank DMA ports, indexed by bank
   , input        [bp_dma_pkg::l2_banks_c-1:0]                pkt_v_i
   , input        [bp_dma_pkg::l2_banks_c-1:0]                pkt_write_not_read_i
   , input  bp_dma_pkg::daddr_t [bp_dma_pkg::l2_banks_c-1:0]  pkt_addr_i
   , output logic [bp_dma_pkg::l2_banks_c-1:0]                pkt_yumi_o

   , input        [bp_dma_pkg::l2_banks_c-1:0]                wdata_v_i
   , input  bp_dma_pkg::fill_t  [bp_dma_pkg::l2_banks_c-1:0]  wdata_i
   , output logic [bp_dma_pkg::l2_banks_c-1:0]                wdata_yumi_o

   , output logic [bp_dma_pkg::l2_banks_c-1:0]                rdata_v_o
   , output bp_dma_pkg::fill_t  [bp_dma_pkg::l2_banks_c-1:0]  rdata_o
   , input        [bp_dma_pkg::l2_banks_c-1:0]                rdata_ready_i

   // Memory port
   , output logic                                             mem_v_o
   , output logic                                             mem_w_o
   , output bp_dma_pkg::paddr_t                               mem_addr_o
   , output bp_dma_pkg::fill_t                                mem_wdata_o
   , input  bp_dma_pkg::fill_t                                mem_rdata_i
   );

   import bp_dma_pkg::*;

   logic   [l2_banks_c-1:0] bus_req;
   logic   [l2_banks_c-1:0] bus_gnt;
   logic   [l2_banks_c-1:0] bus_v;
   logic   [l2_banks_c-1:0] bus_w;
   paddr_t [l2_banks_c-1:0] bus_addr;
   fill_t  [l2_banks_c-1:0] bus_wdata;

   dma_burst_engine engine_0
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.bank_id_i(bank_id_t'(0))
      ,.pkt_v_i(pkt_v_i[0])
      ,.pkt_write_not_read_i(pkt_write_not_read_i[0])
      ,.pkt_addr_i(pkt_addr_i[0])
      ,.pkt_yumi_o(pkt_yumi_o[0])
      ,.wdata_v_i(wdata_v_i[0])
      ,.wdata_i(wdata_i[0])
      ,.wdata_yumi_o(wdata_yumi_o[0])
      ,.rdata_v_o(rdata_v_o[0])
      ,.rdata_o(rdata_o[0])
      ,.rdata_ready_i(rdata_ready_i[0])
      ,.bus_req_o(bus_req[0])
      ,.bus_gnt_i(bus_gnt[0])
      ,.bus_v_o(bus_v[0])
      ,.bus_w_o(bus_w[0])
      ,.bus_addr_o(bus_addr[0])
      ,.bus_wdata_o(bus_wdata[0])
      ,.bus_rdata_i(mem_rdata_i)
      );

   dma_burst_engine engine_1
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.bank_id_i(bank_id_t'(1))
      ,.pkt_v_i(pkt_v_i[1])
      ,.pkt_write_not_read_i(pkt_write_not_read_i[1])
      ,.pkt_addr_i(pkt_addr_i[1])
      ,.pkt_yumi_o(pkt_yumi_o[1])
      ,.wdata_v_i(wdata_v_i[1])
      ,.wdata_i(wdata_i[1])
      ,.wdata_yumi_o(wdata_yumi_o[1])
      ,.rdata_v_o(rdata_v_o[1])
      ,.rdata_o(rdata_o[1])
      ,.rdata_ready_i(rdata_ready_i[1])
      ,.bus_req_o(bus_req[1])
      ,.bus_gnt_i(bus_gnt[1])
      ,.bus_v_o(bus_v[1])
      ,.bus_w_o(bus_w[1])
      ,.bus_addr_o(bus_addr[1])
      ,.bus_wdata_o(bus_wdata[1])
      ,.bus_rdata_i(mem_rdata_i)
      );

   mem_bus_arbiter arbiter
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.req_i(bus_req)
      ,.gnt_o(bus_gnt)
      ,.bus_v_i(bus_v)
      ,.bus_w_i(bus_w)
      ,.bus_addr_i(bus_addr)
      ,.bus_wdata_i(bus_wdata)
      ,.mem_v_o(mem_v_o)
      ,.mem_w_o(mem_w_o)
      ,.mem_addr_o(mem_addr_o)
      ,.mem_wdata_o(mem_wdata_o)
      );

endmodule

// File: source/mem_bus_arbiter.sv
/* Round-robin owner of the shared memory bus and the mux of the
   engine bus signals onto the memory port */

module mem_bus_arbiter
  (input                                                     clk_i
   , input                                                   rst_n_i

   , input        [bp_dma_pkg::l2_banks_c-1:0]               req_i
   , output logic [bp_dma_pkg::l2_banks_c-1:0]               gnt_o

   , input        [bp_dma_pkg::l2_banks_c-1:0]               bus_v_i
   , input        [bp_dma_pkg::l2_banks_c-1:0]               bus_w_i
   , input  bp_dma_pkg::paddr_t [bp_dma_pkg::l2_banks_c-1:0] bus_addr_i
   , input  bp_dma_pkg::fill_t  [bp_dma_pkg::l2_banks_c-1:0] bus_wdata_i

   , output logic                                            mem_v_o
   , output logic                                            mem_w_o
   , output bp_dma_pkg::paddr_t                              mem_addr_o
   , output bp_dma_pkg::fill_t                               mem_wdata_o
   );

   import bp_dma_pkg::*;

   logic [l2_banks_c-1:0] gnt_r;
   logic [l2_banks_c-1:0] gnt_n;
   bank_id_t              last_r;
   bank_id_t              last_n;
   bank_id_t              holder;
   bank_id_t              other;
   logic                  busy;

   assign busy   = (gnt_r != '0);
   assign holder = bank_id_t'(gnt_r[1]);
   assign other  = last_r + 1'b1;

   always_comb
   begin
      gnt_n  = gnt_r;
      last_n = last_r;
      if (busy)
      begin
         // Holder keeps the bus until its request drops
         if (!req_i[holder])
            gnt_n = '0;
      end
      else if (req_i != '0)
      begin
         gnt_n = '0;
         if (req_i[other])
         begin
            gnt_n[other] = 1'b1;
            last_n       = other;
         end
         else
         begin
            gnt_n[last_r] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         gnt_r  <= '0;
         // Bank 0 goes first out of reset
         last_r <= bank_id_t'(l2_banks_c - 1);
      end
      else
      begin
         gnt_r  <= gnt_n;
         last_r <= last_n;
      end
   end

   assign gnt_o = gnt_r;

   assign mem_v_o     = busy & bus_v_i[holder];
   assign mem_w_o     = bus_w_i[holder];
   assign mem_addr_o  = bus_addr_i[holder];
   assign mem_wdata_o = bus_wdata_i[holder];

endmodule

// File: source/dma_burst_engine.sv
/* Per-bank DMA burst engine: packet intake, bank interleave decode
   and single-word accesses on the shared memory bus */

module dma_burst_engine
  (input                            clk_i
   , input                          rst_n_i

   , input  bp_dma_pkg::bank_id_t   bank_id_i

   // DMA packet from the cache bank
   , input                          pkt_v_i
   , input                          pkt_write_not_read_i
   , input  bp_dma_pkg::daddr_t     pkt_addr_i
   , output logic                   pkt_yumi_o

   // Write data from the cache bank
   , input                          wdata_v_i
   , input  bp_dma_pkg::fill_t      wdata_i
   , output logic                   wdata_yumi_o

   // Read data to the cache bank
   , output logic                   rdata_v_o
   , output bp_dma_pkg::fill_t      rdata_o
   , input                          rdata_ready_i

   // Shared bus side
   , output logic                   bus_req_o
   , input                          bus_gnt_i
   , output logic                   bus_v_o
   , output logic                   bus_w_o
   , output bp_dma_pkg::paddr_t     bus_addr_o
   , output bp_dma_pkg::fill_t      bus_wdata_o
   , input  bp_dma_pkg::fill_t      bus_rdata_i
   );

   import bp_dma_pkg::*;

   engine_state_e state_r;
   engine_state_e state_n;
   beat_cnt_t     beat_r;
   beat_cnt_t     beat_n;
   logic          last_beat;

   logic          write_r;
   blk_addr_t     blk_r;
   fill_t         rdata_r;

   assign last_beat = (beat_r == beat_cnt_t'(burst_len_c - 1));

   always_comb
   begin
      state_n = state_r;
      beat_n  = beat_r;
      case (state_r)
         e_idle:
         begin
            if (pkt_v_i)
               state_n = e_wait_grant;
         end
         e_wait_grant:
         begin
            beat_n = '0;
            if (bus_gnt_i)
            begin
               if (write_r)
                  state_n = e_write_beat;
               else
                  state_n = e_read_issue;
            end
         end
         e_write_beat:
         begin
            // One word per cycle, stall while the bank has no data
            if (wdata_v_i)
            begin
               beat_n = beat_r + 1'b1;
               if (last_beat)
                  state_n = e_release;
            end
         end
         e_read_issue:
         begin
            state_n = e_read_capture;
         end
         e_read_capture:
         begin
            state_n = e_read_hold;
         end
         e_read_hold:
         begin
            if (rdata_ready_i)
            begin
               beat_n = beat_r + 1'b1;
               if (last_beat)
                  state_n = e_release;
               else
                  state_n = e_read_issue;
            end
         end
         e_release:
         begin
            state_n = e_idle;
         end
         default:
         begin
            state_n = e_idle;
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         state_r <= e_idle;
         beat_r  <= '0;
      end
      else
      begin
         state_r <= state_n;
         beat_r  <= beat_n;
      end
   end

   // Packet fields and the returned word
   always_ff @(posedge clk_i)
   begin
      if (pkt_yumi_o)
      begin
         write_r <= pkt_write_not_read_i;
         blk_r   <= pkt_addr_i[daddr_width_c-1:beat_width_c];
      end
      // Read data lands one cycle after the strobe
      if (state_r == e_read_capture)
         rdata_r <= bus_rdata_i;
   end

   assign pkt_yumi_o   = (state_r == e_idle) & pkt_v_i;
   assign wdata_yumi_o = (state_r == e_write_beat) & wdata_v_i;

   assign rdata_v_o = (state_r == e_read_hold);
   assign rdata_o   = rdata_r;

   // Request drops in e_release so the arbiter frees the bus
   assign bus_req_o = (state_r != e_idle) && (state_r != e_release);

   assign bus_v_o = ((state_r == e_write_beat) & wdata_v_i)
                    | (state_r == e_read_issue);
   assign bus_w_o = (state_r == e_write_beat);

   // Undo the bank interleave: block bits, bank index, beat
   assign bus_addr_o  = {blk_r, bank_id_i, beat_r};
   assign bus_wdata_o = wdata_i;

endmodule

// File: source/bp_dma_pkg.sv
/* Widths, burst and bank constants, word typedefs and the
   burst engine state encoding */

package bp_dma_pkg;

   localparam int l2_banks_c    = 2;
   localparam int burst_len_c   = 4;
   localparam int fill_width_c  = 32;
   localparam int daddr_width_c = 14;

   localparam int bank_width_c  = $clog2(l2_banks_c);
   localparam int beat_width_c  = $clog2(burst_len_c);
   localparam int paddr_width_c = daddr_width_c + bank_width_c;

   // Block part of a bank-local address, above the beat bits
   localparam int blk_width_c   = daddr_width_c - beat_width_c;

   typedef logic [daddr_width_c-1:0] daddr_t;
   typedef logic [paddr_width_c-1:0] paddr_t;
   typedef logic [fill_width_c-1:0]  fill_t;
   typedef logic [bank_width_c-1:0]  bank_id_t;
   typedef logic [beat_width_c-1:0]  beat_cnt_t;
   typedef logic [blk_width_c-1:0]   blk_addr_t;

   typedef enum logic [2:0]
   {
      e_idle,
      e_wait_grant,
      e_write_beat,
      e_read_issue,
      e_read_capture,
      e_read_hold,
      e_release
   } engine_state_e;

endpackage
